// ==== filelist.f ====
+incdir+source
source/iic_pkg.sv
source/hmc_init_pkg.sv
source/hmc_cmd_rom.sv
source/hmc_byte_shifter.sv
source/hmc_wake_timer.sv
source/hmc_init_fsm.sv
source/iic_write_master.sv
source/hmc_iic_init_top.sv
tb/hmc_iic_init_tb.sv

// ==== source/hmc_byte_shifter.sv ====
// Command word byte shifter, MSB first, with remaining byte count

`timescale 1ns/1ps

module hmc_byte_shifter
  import iic_pkg::*;
  import hmc_init_pkg::*;
(
  input  logic          CLK,
  input  logic          RST,
  input  logic          load_i,
  input  logic          shift_i,
  input  hmc_cmd_word_t word_i,
  input  hmc_byte_cnt_t nbytes_i,
  output iic_byte_t     byte_o,
  output logic          last_o
);

  hmc_cmd_word_t word_q;
  hmc_byte_cnt_t cnt_q;

  // Bytes left after the one on byte_o
  always_ff @(posedge CLK) begin
    if (RST) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= nbytes_i;
    end else if (shift_i && cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (load_i) begin
      word_q <= word_i;
    end else if (shift_i) begin
      word_q <= {word_q[55:0], 8'h00};
    end
  end

  assign byte_o = word_q[63:56];
  assign last_o = (cnt_q == '0);

  // Sequencer must stop shifting once the final byte is presented
  a_no_overshift: assert property (@(posedge CLK) disable iff (RST)
    shift_i |-> cnt_q != '0);

endmodule

// ==== source/hmc_cmd_rom.sv ====
// Step index to slave address, command word and byte count table

`timescale 1ns/1ps
`include "hmc_init_macros.svh"

module hmc_cmd_rom
  import iic_pkg::*;
  import hmc_init_pkg::*;
(
  input  hmc_step_t     step_i,
  output iic_addr_t     slave_o,
  output hmc_cmd_word_t word_o,
  output hmc_byte_cnt_t nbytes_o
);

  localparam hmc_step_t POST_FIRST = hmc_step_t'(`NUM_EXP_STEPS + `NUM_CUBE_STEPS);

  logic          is_exp;
  logic          is_post;
  logic [1:0]    mezz;
  hmc_reg_addr_t reg_addr;
  hmc_reg_data_t reg_data;

  // Expander steps sit before and after the cube block
  assign is_post = (step_i >= POST_FIRST);
  assign is_exp  = (step_i < hmc_step_t'(`NUM_EXP_STEPS)) || is_post;

  // Mezzanine index, mezz 0 set up twice and mezz 3 lit twice
  always_comb begin
    case (step_i)
      5'd2, 5'd19:        mezz = 2'd1;
      5'd3, 5'd20:        mezz = 2'd2;
      5'd4, 5'd21, 5'd22: mezz = 2'd3;
      default:            mezz = 2'd0;
    endcase
  end

  // ##########################################################
  // Cube register sequence
  // ##########################################################
  always_comb begin
    case (step_i)
      5'd5:    {reg_addr, reg_data} = {`HMC_ADDR_CONF_ADDR, `HMC_ADDR_CONF_DATA};
      5'd6:    {reg_addr, reg_data} = {`HMC_RUN_LEN_L2_ADDR, `HMC_RUN_LEN_L2_DATA};
      5'd7:    {reg_addr, reg_data} = {`HMC_RUN_LEN_L3_ADDR, `HMC_RUN_LEN_L3_DATA};
      5'd8:    {reg_addr, reg_data} = {`HMC_RETRY_L2_ADDR, `HMC_RETRY_L2_DATA};
      5'd9:    {reg_addr, reg_data} = {`HMC_RETRY_L3_ADDR, `HMC_RETRY_L3_DATA};
      5'd10:   {reg_addr, reg_data} = {`HMC_TOKEN_L2_ADDR, `HMC_TOKEN_L2_DATA};
      5'd11:   {reg_addr, reg_data} = {`HMC_TOKEN_L3_ADDR, `HMC_TOKEN_L3_DATA};
      5'd12:   {reg_addr, reg_data} = {`HMC_LINK_CFG_L2_ADDR, `HMC_LINK_CFG_L2_DATA};
      5'd13:   {reg_addr, reg_data} = {`HMC_LINK_CFG_L3_ADDR, `HMC_LINK_CFG_L3_DATA};
      5'd14:   {reg_addr, reg_data} = {`HMC_ERI_DATA_L2_ADDR, `HMC_ERI_DATA_L2_DATA};
      5'd15:   {reg_addr, reg_data} = {`HMC_ERI_DATA_L3_ADDR, `HMC_ERI_DATA_L3_DATA};
      5'd16:   {reg_addr, reg_data} = {`HMC_ERI_LINK_SETUP_ADDR, `HMC_ERI_LINK_SETUP_DATA};
      // Last one kicks off link init in the cube
      5'd17:   {reg_addr, reg_data} = {`HMC_ERI_INIT_CONT_ADDR, `HMC_ERI_INIT_CONT_DATA};
      default: {reg_addr, reg_data} = '0;
    endcase
  end

  // Expanders take 2 bytes, the cube 8
  assign slave_o  = is_exp ? iic_addr_t'(`IO_EXP_BASE_ADDR + {5'd0, mezz}) : `HMC_CUBE_ADDR;
  assign nbytes_o = is_exp ? hmc_byte_cnt_t'(1) : hmc_byte_cnt_t'(7);

  always_comb begin
    if (!is_exp)
      word_o = {reg_addr, reg_data};
    else if (is_post)
      word_o = {`IO_EXP_POST_WORD, 48'd0};
    else
      word_o = {`IO_EXP_SETUP_WORD, 48'd0};
  end

endmodule

// ==== source/hmc_iic_init_top.sv ====
// HMC power-up initializer top level, sequencer, table, shifter, timer and IIC master

`timescale 1ns/1ps
`include "hmc_init_macros.svh"

module hmc_iic_init_top
  import iic_pkg::*;
  import hmc_init_pkg::*;
#(
  parameter int CLK_DIV     = `DEF_CLK_DIV,
  parameter int WAKE_CYCLES = `DEF_WAKE_CYCLES
) (
  input  logic CLK,
  input  logic RST,
  input  logic hmc_post_done_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_o,
  output logic sda_o,
  output logic hmc_reset_o,
  output logic init_done_o,
  output logic post_done_latch_o,
  output logic iic_busy_o,
  output logic iic_ack_err_o
);

  hmc_step_t     step;
  iic_addr_t     slave;
  hmc_cmd_word_t word;
  hmc_byte_cnt_t nbytes;
  iic_byte_t     cur_byte;
  logic          load;
  logic          shift;
  logic          last;
  logic          iic_ena;
  logic          mst_busy;
  logic          wake_ok;

  hmc_init_fsm u_fsm (
    .CLK               (CLK),
    .RST               (RST),
    .hmc_post_done_i   (hmc_post_done_i),
    .wake_ok_i         (wake_ok),
    .iic_busy_i        (mst_busy),
    .last_i            (last),
    .step_o            (step),
    .load_o            (load),
    .shift_o           (shift),
    .iic_ena_o         (iic_ena),
    .hmc_reset_o       (hmc_reset_o),
    .init_done_o       (init_done_o),
    .post_done_latch_o (post_done_latch_o),
    .seq_busy_o        (iic_busy_o)
  );

  // Wake time runs from cube reset release
  hmc_wake_timer #(
    .WAKE_CYCLES (WAKE_CYCLES)
  ) u_wake (
    .CLK             (CLK),
    .RST             (RST),
    .cube_released_i (!hmc_reset_o),
    .wake_ok_o       (wake_ok)
  );

  hmc_cmd_rom u_rom (
    .step_i   (step),
    .slave_o  (slave),
    .word_o   (word),
    .nbytes_o (nbytes)
  );

  hmc_byte_shifter u_shift (
    .CLK      (CLK),
    .RST      (RST),
    .load_i   (load),
    .shift_i  (shift),
    .word_i   (word),
    .nbytes_i (nbytes),
    .byte_o   (cur_byte),
    .last_o   (last)
  );

  // Open-drain style, 1 on scl_o or sda_o releases the line
  iic_write_master #(
    .CLK_DIV (CLK_DIV)
  ) u_iic (
    .CLK       (CLK),
    .RST       (RST),
    .ena_i     (iic_ena),
    .addr_i    (slave),
    .byte_i    (cur_byte),
    .scl_i     (scl_i),
    .sda_i     (sda_i),
    .busy_o    (mst_busy),
    .ack_err_o (iic_ack_err_o),
    .scl_o     (scl_o),
    .sda_o     (sda_o)
  );

endmodule

// ==== source/hmc_init_fsm.sv ====
// Init sequencer FSM with step counter, POST-done synchronizer and status flags

`timescale 1ns/1ps
`include "hmc_init_macros.svh"

module hmc_init_fsm
  import hmc_init_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      hmc_post_done_i,
  input  logic      wake_ok_i,
  input  logic      iic_busy_i,
  input  logic      last_i,
  output hmc_step_t step_o,
  output logic      load_o,
  output logic      shift_o,
  output logic      iic_ena_o,
  output logic      hmc_reset_o,
  output logic      init_done_o,
  output logic      post_done_latch_o,
  output logic      seq_busy_o
);

  localparam hmc_step_t INIT_STEPS   = hmc_step_t'(`NUM_EXP_STEPS + `NUM_CUBE_STEPS);
  localparam hmc_step_t ALL_STEPS    = hmc_step_t'(INIT_STEPS + `NUM_POST_STEPS);
  localparam hmc_step_t RELEASE_STEP = hmc_step_t'(`NUM_EXP_STEPS - 1);
  localparam hmc_step_t LAST_STEP    = hmc_step_t'(ALL_STEPS - 1);

  hmc_seq_state_t state_q;
  hmc_step_t      step_q;
  hmc_step_t      limit;
  logic           ena_q;
  logic           miss_q;
  logic           all_sent_q;
  logic           reset_q;
  logic           done_q;
  logic           post_ext_q;
  logic           latch_arm_q;
  logic           latch_q;
  logic [2:0]     post_q;
  logic           post_edge;

  // Two sync flops, third one for the edge, only the first edge counts
  assign post_edge = post_q[1] && !post_q[2] && !post_ext_q;
  assign limit     = post_ext_q ? ALL_STEPS : INIT_STEPS;

  // ##########################################################
  // Sequencer
  // ##########################################################
  always_ff @(posedge CLK) begin
    if (RST) begin
      state_q     <= IDLE;
      step_q      <= '0;
      ena_q       <= 1'b0;
      miss_q      <= 1'b0;
      all_sent_q  <= 1'b0;
      reset_q     <= 1'b1;
      done_q      <= 1'b0;
      post_ext_q  <= 1'b0;
      latch_arm_q <= 1'b0;
      latch_q     <= 1'b0;
      post_q      <= '0;
    end else begin
      post_q  <= {post_q[1:0], hmc_post_done_i};
      latch_q <= latch_arm_q;
      if (post_edge) begin
        post_ext_q <= 1'b1;
      end
      case (state_q)
        IDLE: begin
          if (wake_ok_i) begin
            if (step_q < limit && !all_sent_q) begin
              state_q <= LOAD;
            end else begin
              done_q <= 1'b1;
            end
          end
        end
        // Shifter loads now, first byte offered next cycle
        LOAD: begin
          ena_q   <= 1'b1;
          miss_q  <= 1'b0;
          state_q <= WAIT_BUSY;
          if (step_q == RELEASE_STEP) begin
            reset_q <= 1'b0;
          end
          if (step_q == LAST_STEP) begin
            latch_arm_q <= 1'b1;
          end
        end
        // Byte accepted: queue the next one or mark this as last
        WAIT_BUSY: begin
          if (iic_busy_i) begin
            if (last_i) begin
              ena_q <= 1'b0;
            end
            state_q <= WAIT_DONE;
          end else if (miss_q) begin
            // Master ended early on a NACK and will not restart
            ena_q   <= 1'b0;
            state_q <= NEXT;
          end else begin
            miss_q <= 1'b1;
          end
        end
        WAIT_DONE: begin
          if (!iic_busy_i) begin
            miss_q  <= 1'b0;
            state_q <= ena_q ? WAIT_BUSY : NEXT;
          end
        end
        NEXT: begin
          if (step_q == LAST_STEP) begin
            all_sent_q <= 1'b1;
          end else begin
            step_q <= step_q + 1'b1;
          end
          state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign step_o            = step_q;
  assign load_o            = (state_q == LOAD);
  assign shift_o           = (state_q == WAIT_BUSY) && iic_busy_i && !last_i;
  assign iic_ena_o         = ena_q;
  assign hmc_reset_o       = reset_q;
  assign init_done_o       = done_q;
  assign post_done_latch_o = latch_q;
  assign seq_busy_o        = (state_q != IDLE);

  // Master would start a stray transfer if ENA were left up between steps
  a_no_ena_idle: assert property (@(posedge CLK) disable iff (RST)
    (state_q == IDLE) |-> !ena_q);

  a_step_range: assert property (@(posedge CLK) disable iff (RST)
    step_q < ALL_STEPS);

endmodule

// ==== source/hmc_init_macros.svh ====
// Bus addresses, step counts, expander words, cube register values and default timing

`ifndef HMC_INIT_MACROS_SVH
`define HMC_INIT_MACROS_SVH

// ##########################################################
// IIC slave addresses and step counts
// ##########################################################
`define HMC_CUBE_ADDR     7'h10
`define IO_EXP_BASE_ADDR  7'h20
// Config reg 0x03, P4 and P7 inputs, LED and link power-down outputs
`define IO_EXP_SETUP_WORD 16'h0397
// Output reg 0x01, P6 low lights the POST LED
`define IO_EXP_POST_WORD  16'h01BF
`define NUM_EXP_STEPS     5
`define NUM_CUBE_STEPS    13
`define NUM_POST_STEPS    5

// ##########################################################
// Cube register writes, 10G half width on links 2 and 3
// ##########################################################
`define HMC_ADDR_CONF_ADDR       32'h002C0000
`define HMC_ADDR_CONF_DATA       32'h00000002
`define HMC_RUN_LEN_L2_ADDR      32'h00260003
`define HMC_RUN_LEN_L2_DATA      32'h003C0000
`define HMC_RUN_LEN_L3_ADDR      32'h00270003
`define HMC_RUN_LEN_L3_DATA      32'h003C0000
// Retry on, limit 3, timeout 820ns, 6 IRTRY sent, 16 IRTRY received
`define HMC_RETRY_L2_ADDR        32'h000E0000
`define HMC_RETRY_L2_DATA        32'h00100657
`define HMC_RETRY_L3_ADDR        32'h000F0000
`define HMC_RETRY_L3_DATA        32'h00100657
// 219 input buffer tokens per link
`define HMC_TOKEN_L2_ADDR        32'h00060000
`define HMC_TOKEN_L2_DATA        32'h000000DB
`define HMC_TOKEN_L3_ADDR        32'h00070000
`define HMC_TOKEN_L3_DATA        32'h000000DB
// Host source link, all checks and scramblers on, error responses on
`define HMC_LINK_CFG_L2_ADDR     32'h00260000
`define HMC_LINK_CFG_L2_DATA     32'h00000FF9
`define HMC_LINK_CFG_L3_ADDR     32'h00270000
`define HMC_LINK_CFG_L3_DATA     32'h00000FF9
`define HMC_ERI_DATA_L2_ADDR     32'h002B0002
`define HMC_ERI_DATA_L2_DATA     32'h10010000
`define HMC_ERI_DATA_L3_ADDR     32'h002B0003
`define HMC_ERI_DATA_L3_DATA     32'h10010000
`define HMC_ERI_LINK_SETUP_ADDR  32'h002B0004
`define HMC_ERI_LINK_SETUP_DATA  32'h813F0005
`define HMC_ERI_INIT_CONT_ADDR   32'h002B0004
`define HMC_ERI_INIT_CONT_DATA   32'h800000FF

// System clocks per quarter SCL period and cube wake-up time
`define DEF_CLK_DIV     3900
`define DEF_WAKE_CYCLES 78000000

`endif

// ==== source/hmc_init_pkg.sv ====
// Cube register types, command word, step index, byte count and sequencer enum

package hmc_init_pkg;

  typedef logic [31:0] hmc_reg_addr_t;
  typedef logic [31:0] hmc_reg_data_t;

  // Register address in the upper half, expander words left-aligned
  typedef logic [63:0] hmc_cmd_word_t;

  // Covers expander, cube and POST steps
  typedef logic [4:0] hmc_step_t;

  // Bytes per command minus one
  typedef logic [2:0] hmc_byte_cnt_t;

  // Sequencer states
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    WAIT_BUSY,
    WAIT_DONE,
    NEXT
  } hmc_seq_state_t;

endpackage

// ==== source/hmc_wake_timer.sv ====
// Cube wake-up counter with pre- and post-release thresholds

`timescale 1ns/1ps
`include "hmc_init_macros.svh"

module hmc_wake_timer #(
  parameter int WAKE_CYCLES = `DEF_WAKE_CYCLES
) (
  input  logic CLK,
  input  logic RST,
  input  logic cube_released_i,
  output logic wake_ok_o
);

  logic [31:0] cnt_q;
  logic [31:0] threshold;
  logic        released_q;

  // Short wait while the cube is held, full wake time after release
  assign threshold = released_q ? 32'(WAKE_CYCLES) : 32'd1;

  always_ff @(posedge CLK) begin
    if (RST) begin
      cnt_q      <= '0;
      released_q <= 1'b0;
    end else begin
      released_q <= cube_released_i;
      // Restart on release so the wake time counts from there
      if (cube_released_i && !released_q) begin
        cnt_q <= '0;
      end else if (cnt_q != '1) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign wake_ok_o = (cnt_q > threshold);

endmodule

// ==== source/iic_pkg.sv ====
// IIC address and data byte types, bit engine phase enum

package iic_pkg;

  // 7-bit slave address, R/W bit added by the bit engine
  typedef logic [6:0] iic_addr_t;

  typedef logic [7:0] iic_byte_t;

  // Bit engine phases, one per bus segment
  typedef enum logic [2:0] {
    IDLE,
    START,
    ADDR,
    ADDR_ACK,
    DATA,
    DATA_ACK,
    STOP
  } iic_phase_t;

endpackage

// ==== source/iic_write_master.sv ====
// Write-only IIC bit engine with START, address, data, STOP and ACK check

`timescale 1ns/1ps
`include "hmc_init_macros.svh"

module iic_write_master
  import iic_pkg::*;
#(
  parameter int CLK_DIV = `DEF_CLK_DIV
) (
  input  logic      CLK,
  input  logic      RST,
  input  logic      ena_i,
  input  iic_addr_t addr_i,
  input  iic_byte_t byte_i,
  input  logic      scl_i,
  input  logic      sda_i,
  output logic      busy_o,
  output logic      ack_err_o,
  output logic      scl_o,
  output logic      sda_o
);

  localparam int DIV_W = $clog2(CLK_DIV + 1);

  iic_phase_t       phase_q;
  logic [DIV_W-1:0] div_q;
  logic [1:0]       qtr_q;
  logic [2:0]       bit_q;
  iic_addr_t        addr_q;
  iic_byte_t        byte_q;
  iic_byte_t        sh_q;
  logic             nack_q;
  logic             hold_q;
  logic             busy_q;
  logic             ack_err_q;
  logic             start;
  logic             stretch;
  logic             tick;

  // After a NACK, wait for ENA to drop before the next transfer
  assign start   = (phase_q == IDLE) && ena_i && !hold_q;
  // A slave holding SCL low stalls the divider
  assign stretch = scl_o && !scl_i;
  assign tick    = (phase_q != IDLE) && !stretch && (div_q == DIV_W'(CLK_DIV - 1));

  always_ff @(posedge CLK) begin
    if (RST || phase_q == IDLE || tick) begin
      div_q <= '0;
    end else if (!stretch) begin
      div_q <= div_q + 1'b1;
    end
  end

  // ##########################################################
  // Bus waveform, one bit is four quarters: low, high, high, low
  // ##########################################################
  always_comb begin
    scl_o = 1'b1;
    sda_o = 1'b1;
    case (phase_q)
      START: begin
        scl_o = (qtr_q != 2'd3);
        sda_o = (qtr_q == 2'd0);
      end
      ADDR, DATA: begin
        scl_o = qtr_q inside {2'd1, 2'd2};
        sda_o = sh_q[7];
      end
      // SDA released for the slave ACK
      ADDR_ACK, DATA_ACK: scl_o = qtr_q inside {2'd1, 2'd2};
      STOP: begin
        scl_o = (qtr_q != 2'd0);
        sda_o = (qtr_q >= 2'd2);
      end
      default: ;
    endcase
  end

  // ##########################################################
  // Phase control
  // ##########################################################
  always_ff @(posedge CLK) begin
    if (RST) begin
      phase_q   <= IDLE;
      qtr_q     <= '0;
      bit_q     <= '0;
      nack_q    <= 1'b0;
      hold_q    <= 1'b0;
      busy_q    <= 1'b0;
      ack_err_q <= 1'b0;
    end else begin
      if (!ena_i) begin
        hold_q <= 1'b0;
      end
      if (phase_q == IDLE) begin
        qtr_q <= '0;
        if (start) begin
          phase_q   <= START;
          busy_q    <= 1'b1;
          ack_err_q <= 1'b0;
        end
      end else begin
        // Busy comes back after the one-cycle drop between bytes
        busy_q <= 1'b1;
        if (tick) begin
          qtr_q <= qtr_q + 1'b1;
          // ACK sampled at the end of the first high quarter
          if (qtr_q == 2'd1) begin
            nack_q <= sda_i;
          end
          if (qtr_q == 2'd3) begin
            case (phase_q)
              START: begin
                phase_q <= ADDR;
                bit_q   <= 3'd7;
              end
              ADDR, DATA: begin
                bit_q <= bit_q - 1'b1;
                if (bit_q == 3'd0) begin
                  phase_q <= (phase_q == ADDR) ? ADDR_ACK : DATA_ACK;
                end
              end
              ADDR_ACK, DATA_ACK: begin
                bit_q <= 3'd7;
                if (nack_q) begin
                  ack_err_q <= 1'b1;
                  hold_q    <= 1'b1;
                  phase_q   <= STOP;
                end else if (phase_q == ADDR_ACK) begin
                  phase_q <= DATA;
                end else if (ena_i) begin
                  // Next byte taken from byte_i on this edge
                  phase_q <= DATA;
                  busy_q  <= 1'b0;
                end else begin
                  phase_q <= STOP;
                end
              end
              default: begin
                phase_q <= IDLE;
                busy_q  <= 1'b0;
              end
            endcase
          end
        end
      end
    end
  end

  // Address and data payload
  always_ff @(posedge CLK) begin
    if (start) begin
      addr_q <= addr_i;
      byte_q <= byte_i;
    end
    if (tick && qtr_q == 2'd3) begin
      case (phase_q)
        START:      sh_q <= {addr_q, 1'b0};
        ADDR, DATA: sh_q <= {sh_q[6:0], 1'b0};
        ADDR_ACK:   sh_q <= byte_q;
        DATA_ACK:   sh_q <= byte_i;
        default:    ;
      endcase
    end
  end

  assign busy_o    = busy_q;
  assign ack_err_o = ack_err_q;

  // Data changes with SCL high would be seen as START or STOP by the slave
  a_sda_scl_low: assert property (@(posedge CLK) disable iff (RST)
    (phase_q inside {ADDR, ADDR_ACK, DATA, DATA_ACK} && $changed(sda_o)) |-> !scl_o);

endmodule

// ==== tb/hmc_iic_init_tb.sv ====
// HMC initializer testbench with clock, reset, IIC slave model, reference steps and scenario

`timescale 1ns/1ps
`include "hmc_init_macros.svh"

module hmc_iic_init_tb
  import iic_pkg::*;
  import hmc_init_pkg::*;
;

  localparam int WAKE = 2000;
  localparam int TOTAL_STEPS = `NUM_EXP_STEPS + `NUM_CUBE_STEPS + `NUM_POST_STEPS;

  logic CLK;
  logic RST;
  logic hmc_post_done_i;
  logic scl_o;
  logic sda_o;
  logic hmc_reset_o;
  logic init_done_o;
  logic post_done_latch_o;
  logic iic_busy_o;
  logic iic_ack_err_o;
  logic scl_bus;
  logic sda_bus;

  int err_value;
  int err_other;

  // Slave model state
  logic        ack_drive;
  logic        in_xfer;
  logic        in_ack;
  logic        first;
  int          bitcnt;
  logic [7:0]  sh;
  iic_addr_t   cur_addr;
  int          cur_n;
  logic [63:0] cur_word;
  realtime     t_start;
  realtime     t_release;
  iic_addr_t   nack_addr;

  // One entry per transfer seen on the bus
  iic_addr_t   xfer_addr[$];
  int          xfer_n[$];
  logic [63:0] xfer_word[$];
  realtime     xfer_t[$];

  // Open drain bus where the slave only pulls SDA low
  assign scl_bus = scl_o;
  assign sda_bus = sda_o & ~ack_drive;

  hmc_iic_init_top #(
    .CLK_DIV     (4),
    .WAKE_CYCLES (WAKE)
  ) dut_i (
    .CLK               (CLK),
    .RST               (RST),
    .hmc_post_done_i   (hmc_post_done_i),
    .scl_i             (scl_bus),
    .sda_i             (sda_bus),
    .scl_o             (scl_o),
    .sda_o             (sda_o),
    .hmc_reset_o       (hmc_reset_o),
    .init_done_o       (init_done_o),
    .post_done_latch_o (post_done_latch_o),
    .iic_busy_o        (iic_busy_o),
    .iic_ack_err_o     (iic_ack_err_o)
  );

  initial CLK = 1'b0;
  always #5 CLK = ~CLK;

  always @(negedge hmc_reset_o) t_release = $realtime;

  // ##########################################################
  // IIC slave model
  // ##########################################################
  // START is SDA falling with SCL high
  always @(negedge sda_bus) begin
    if (scl_bus === 1'b1 && RST === 1'b0) begin
      in_xfer  = 1'b1;
      first    = 1'b1;
      in_ack   = 1'b0;
      bitcnt   = 0;
      cur_n    = 0;
      cur_word = '0;
      t_start  = $realtime;
    end
  end

  // STOP closes the record
  always @(posedge sda_bus) begin
    if (scl_bus === 1'b1 && in_xfer) begin
      xfer_addr.push_back(cur_addr);
      xfer_n.push_back(cur_n);
      xfer_word.push_back(cur_word);
      xfer_t.push_back(t_start);
      in_xfer = 1'b0;
    end
  end

  // Data valid while SCL high
  always @(posedge scl_bus) begin
    if (in_xfer && !in_ack && bitcnt < 8) begin
      sh     = {sh[6:0], sda_bus};
      bitcnt = bitcnt + 1;
    end
  end

  // ACK slot opens and closes on SCL falling edges
  always @(negedge scl_bus) begin
    if (in_xfer) begin
      if (in_ack) begin
        in_ack    = 1'b0;
        ack_drive = 1'b0;
        bitcnt    = 0;
      end else if (bitcnt == 8) begin
        in_ack = 1'b1;
        if (first) begin
          first     = 1'b0;
          cur_addr  = sh[7:1];
          ack_drive = (sh[7:1] != nack_addr);
        end else begin
          cur_word  = cur_word | ({56'd0, sh} << (56 - 8 * cur_n));
          cur_n     = cur_n + 1;
          ack_drive = 1'b1;
        end
      end
    end
  end

  // ##########################################################
  // Reference and compare tasks
  // ##########################################################
  // Expected slave, byte count and left-aligned bytes per step
  function automatic iic_addr_t ref_step(input int step, output int nb, output logic [63:0] w);
    iic_addr_t a;
    nb = 2;
    if (step < 5) begin
      a = (step == 0) ? 7'h20 : iic_addr_t'(7'h1F + step);
      w = {`IO_EXP_SETUP_WORD, 48'd0};
    end else if (step >= 18) begin
      a = (step == 22) ? 7'h23 : iic_addr_t'(7'h20 + step - 18);
      w = {`IO_EXP_POST_WORD, 48'd0};
    end else begin
      a  = `HMC_CUBE_ADDR;
      nb = 8;
      case (step)
        5:       w = {`HMC_ADDR_CONF_ADDR, `HMC_ADDR_CONF_DATA};
        6:       w = {`HMC_RUN_LEN_L2_ADDR, `HMC_RUN_LEN_L2_DATA};
        7:       w = {`HMC_RUN_LEN_L3_ADDR, `HMC_RUN_LEN_L3_DATA};
        8:       w = {`HMC_RETRY_L2_ADDR, `HMC_RETRY_L2_DATA};
        9:       w = {`HMC_RETRY_L3_ADDR, `HMC_RETRY_L3_DATA};
        10:      w = {`HMC_TOKEN_L2_ADDR, `HMC_TOKEN_L2_DATA};
        11:      w = {`HMC_TOKEN_L3_ADDR, `HMC_TOKEN_L3_DATA};
        12:      w = {`HMC_LINK_CFG_L2_ADDR, `HMC_LINK_CFG_L2_DATA};
        13:      w = {`HMC_LINK_CFG_L3_ADDR, `HMC_LINK_CFG_L3_DATA};
        14:      w = {`HMC_ERI_DATA_L2_ADDR, `HMC_ERI_DATA_L2_DATA};
        15:      w = {`HMC_ERI_DATA_L3_ADDR, `HMC_ERI_DATA_L3_DATA};
        16:      w = {`HMC_ERI_LINK_SETUP_ADDR, `HMC_ERI_LINK_SETUP_DATA};
        default: w = {`HMC_ERI_INIT_CONT_ADDR, `HMC_ERI_INIT_CONT_DATA};
      endcase
    end
    return a;
  endfunction

  task automatic check_addr(input string name, input iic_addr_t got, input iic_addr_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      err_value++;
    end
  endtask

  task automatic check_byte(input string name, input iic_byte_t got, input iic_byte_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      err_value++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      err_value++;
    end
  endtask

  // Compares recorded transfers lo..hi against the reference
  task automatic check_xfers(input int lo, input int hi);
    int          nb;
    logic [63:0] w;
    iic_addr_t   a;
    for (int i = lo; i <= hi; i++) begin
      a = ref_step(i, nb, w);
      if (a == nack_addr) begin
        nb = 0;
      end
      check_addr($sformatf("xfer[%0d].addr", i), xfer_addr[i], a);
      if (xfer_n[i] != nb) begin
        $display("CHECK FAILED xfer[%0d].nbytes got 0x%0h expected 0x%0h", i, xfer_n[i], nb);
        err_value++;
      end
      for (int b = 0; b < nb; b++) begin
        check_byte($sformatf("xfer[%0d].byte[%0d]", i, b),
                   xfer_word[i][63 - 8 * b -: 8], w[63 - 8 * b -: 8]);
      end
    end
  endtask

  // ##########################################################
  // Wait loops with timeouts
  // ##########################################################
  task automatic wait_xfers(input int n, input int limit);
    int cyc;
    cyc = 0;
    while (xfer_addr.size() < n && cyc < limit) begin
      @(negedge CLK);
      cyc++;
    end
    if (xfer_addr.size() < n) begin
      $display("Timed out waiting for transfer %0d, only %0d seen", n, xfer_addr.size());
      err_other++;
    end
  endtask

  task automatic wait_high(input string name, ref logic sig, input int limit);
    int cyc;
    cyc = 0;
    while (sig !== 1'b1 && cyc < limit) begin
      @(negedge CLK);
      cyc++;
    end
    if (sig !== 1'b1) begin
      $display("Timed out waiting for %s to go high", name);
      err_other++;
    end
  endtask

  task automatic apply_reset(input iic_addr_t nack);
    @(posedge CLK);
    #1;
    RST             = 1'b1;
    hmc_post_done_i = 1'b0;
    nack_addr       = nack;
    ack_drive       = 1'b0;
    in_xfer         = 1'b0;
    xfer_addr.delete();
    xfer_n.delete();
    xfer_word.delete();
    xfer_t.delete();
    repeat (7) @(posedge CLK);
    // Reset values while still in reset
    @(negedge CLK);
    check_flag("hmc_reset_o", hmc_reset_o, 1'b1);
    check_flag("init_done_o", init_done_o, 1'b0);
    check_flag("iic_busy_o", iic_busy_o, 1'b0);
    check_flag("post_done_latch_o", post_done_latch_o, 1'b0);
    check_flag("iic_ack_err_o", iic_ack_err_o, 1'b0);
    check_flag("scl_o", scl_o, 1'b1);
    check_flag("sda_o", sda_o, 1'b1);
    @(posedge CLK);
    #1;
    RST = 1'b0;
  endtask

  // ##########################################################
  // Scenario
  // ##########################################################
  initial begin
    RST             = 1'b1;
    hmc_post_done_i = 1'b0;
    nack_addr       = 7'h7F;
    ack_drive       = 1'b0;
    in_xfer         = 1'b0;
    in_ack          = 1'b0;
    first           = 1'b0;
    bitcnt          = 0;
    err_value       = 0;
    err_other       = 0;
    t_release       = 0;

    // Run 1 with every slave acknowledging
    apply_reset(7'h7F);
    wait_xfers(5, 20000);
    check_flag("hmc_reset_o", hmc_reset_o, 1'b0);
    wait_xfers(18, 60000);
    wait_high("init_done_o", init_done_o, 2000);
    check_xfers(0, xfer_addr.size() < 18 ? xfer_addr.size() - 1 : 17);
    if (xfer_t.size() > 5 && (xfer_t[5] - t_release) / 10.0 < WAKE) begin
      $display("First cube transfer started before the wake time elapsed");
      err_other++;
    end
    @(negedge CLK);
    check_flag("iic_busy_o", iic_busy_o, 1'b0);

    // POST done extends the sequence
    @(posedge CLK);
    #1;
    hmc_post_done_i = 1'b1;
    wait_high("post_done_latch_o", post_done_latch_o, 20000);
    wait_xfers(TOTAL_STEPS, 20000);
    if (xfer_addr.size() >= TOTAL_STEPS) begin
      check_xfers(18, TOTAL_STEPS - 1);
    end
    repeat (20) @(posedge CLK);
    #1;
    hmc_post_done_i = 1'b0;
    repeat (20) @(posedge CLK);
    #1;
    hmc_post_done_i = 1'b1;
    // Observation window for stray transfers
    repeat (3000) @(posedge CLK);
    @(negedge CLK);
    if (xfer_addr.size() != TOTAL_STEPS) begin
      $display("Second POST pulse led to %0d transfers in total", xfer_addr.size());
      err_other++;
    end
    check_flag("init_done_o", init_done_o, 1'b1);
    check_flag("post_done_latch_o", post_done_latch_o, 1'b1);

    // Run 2 where the expander at 0x22 NACKs its address
    apply_reset(7'h22);
    wait_high("iic_ack_err_o", iic_ack_err_o, 20000);
    wait_xfers(18, 60000);
    wait_high("init_done_o", init_done_o, 2000);
    check_xfers(0, xfer_addr.size() < 18 ? xfer_addr.size() - 1 : 17);

    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
